/* src/sched_settings.svh */
`ifndef SCHED_SETTINGS_SVH
`define SCHED_SETTINGS_SVH

// Interface, core and slot counts
`define SCHED_IF_COUNT        3
`define SCHED_CORE_COUNT      8
`define SCHED_SLOT_COUNT      32

// Lowest hash bit of the destination core select
`define SCHED_HASH_SEL_OFFSET 14

`define SCHED_HASH_FIFO_DEPTH 8
`define SCHED_DESC_FIFO_DEPTH 8

// Receive buffer fill level in lines
`define SCHED_LINES_WIDTH     13
`define SCHED_DROP_LIMIT_RST  3584

// Readback for registers that have none
`define SCHED_RD_DEFAULT      32'hFEFEFEFE

`endif

/* src/sched_pkg.sv */
`include "sched_settings.svh"

package sched_pkg;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0]   core_id_t;
  typedef logic [$clog2(`SCHED_IF_COUNT)-1:0]     if_id_t;
  // Wide enough to hold a full count of slots
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;
  typedef logic [31:0]                            hash_t;
  typedef logic [`SCHED_CORE_COUNT-1:0]           core_mask_t;
  typedef logic [`SCHED_LINES_WIDTH-1:0]          line_count_t;

  // Core control message, type in the top nibble
  typedef struct packed {
    logic [3:0]  msg_type;
    logic [9:0]  rsvd_hi;
    slot_t       slot;
    logic [15:0] rsvd_lo;
  } ctrl_msg_t;

  localparam logic [3:0] MSG_SLOT_RETURN = 4'd0;
  localparam logic [3:0] MSG_SLOT_INIT   = 4'd3;

  typedef struct packed {
    logic     drop;
    hash_t    hash;
    core_id_t core;
    slot_t    slot;
  } alloc_desc_t;

  // Upper bit selects interface registers over core registers
  typedef enum logic [4:0] {
    CORE_ENABLE     = 5'h00,
    CORE_INCOME     = 5'h01,
    CORE_FLUSH      = 5'h02,
    CORE_SLOT_COUNT = 5'h03,
    IF_DROP_COUNT   = 5'h12,
    IF_DROP_LIMIT   = 5'h13
  } host_reg_e;

endpackage

/* src/sched_fifo.sv */
`timescale 1ns/1ps

module sched_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk,
  input  logic     rst_r,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  localparam int AW = $clog2(DEPTH);

  payload_t      mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic [AW:0]   count_next;
  logic          push;
  logic          pop;

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !pop)
      count_next = count + 1'b1;
    else if (pop && !push)
      count_next = count - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count    <= count_next;
      // Ready rises one cycle after reset and falls with the last free entry
      in_ready <= (count_next != (AW + 1)'(DEPTH));
    end
  end

endmodule

/* src/slot_keeper.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module slot_keeper (
  input  logic             clk,
  input  logic             rst_r,
  input  sched_pkg::slot_t init_count,
  input  logic             init_valid,
  input  sched_pkg::slot_t slot_in,
  input  logic             slot_in_valid,
  output sched_pkg::slot_t slot_out,
  output logic             slot_out_valid,
  input  logic             slot_out_pop,
  output sched_pkg::slot_t slot_count,
  output logic             enq_err
);

  import sched_pkg::*;

  localparam int    PW         = $clog2(`SCHED_SLOT_COUNT);
  localparam slot_t FULL_COUNT = slot_t'(`SCHED_SLOT_COUNT);

  slot_t         mem [`SCHED_SLOT_COUNT];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  slot_t         init_clamped;
  logic          push;
  logic          pop;

  assign init_clamped   = (init_count > FULL_COUNT) ? FULL_COUNT : init_count;
  assign slot_out       = mem[rd_ptr];
  assign slot_out_valid = (slot_count != '0);
  assign pop            = slot_out_pop && slot_out_valid;
  // A return into a full queue is lost and flagged
  assign push           = slot_in_valid && (slot_count != FULL_COUNT);
  assign enq_err        = slot_in_valid && (slot_count == FULL_COUNT);

  // Init refills the whole ring with slots 1 and up
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < `SCHED_SLOT_COUNT; i++)
        mem[i] <= slot_t'(i + 1);
    end else if (push) begin
      mem[wr_ptr] <= slot_in;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      slot_count <= '0;
    end else if (init_valid) begin
      rd_ptr     <= '0;
      wr_ptr     <= init_clamped[PW-1:0];
      slot_count <= init_clamped;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        slot_count <= slot_count + 1'b1;
      else if (pop && !push)
        slot_count <= slot_count - 1'b1;
    end
  end

endmodule

/* src/core_slot_pool.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module core_slot_pool (
  input  logic                                     clk,
  input  logic                                     rst_r,
  input  logic                                     ctrl_valid,
  input  sched_pkg::ctrl_msg_t                     ctrl_data,
  input  sched_pkg::core_id_t                      ctrl_core,
  input  sched_pkg::core_mask_t                    flush,
  input  sched_pkg::core_mask_t                    slot_pop,
  output sched_pkg::slot_t [`SCHED_CORE_COUNT-1:0] head_slot,
  output sched_pkg::core_mask_t                    slot_valid,
  output sched_pkg::slot_t [`SCHED_CORE_COUNT-1:0] slot_count,
  output logic                                     slot_err
);

  import sched_pkg::*;

  slot_t      msg_slot;
  core_mask_t init_v;
  core_mask_t return_v;
  core_mask_t keeper_err;

  // Same field carries the init count and the returned slot
  always_ff @(posedge clk) begin
    msg_slot <= ctrl_data.slot;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      init_v   <= '0;
      return_v <= '0;
      slot_err <= 1'b0;
    end else begin
      for (int i = 0; i < `SCHED_CORE_COUNT; i++) begin
        init_v[i]   <= ctrl_valid && (ctrl_data.msg_type == MSG_SLOT_INIT) &&
                       (ctrl_core == core_id_t'(i));
        return_v[i] <= ctrl_valid && (ctrl_data.msg_type == MSG_SLOT_RETURN) &&
                       (ctrl_core == core_id_t'(i));
      end
      slot_err <= |keeper_err;
    end
  end

  for (genvar i = 0; i < `SCHED_CORE_COUNT; i++) begin : g_core
    // Flush empties this core only
    slot_keeper u_keeper (
      .clk            (clk),
      .rst_r          (rst_r || flush[i]),
      .init_count     (msg_slot),
      .init_valid     (init_v[i]),
      .slot_in        (msg_slot),
      .slot_in_valid  (return_v[i]),
      .slot_out       (head_slot[i]),
      .slot_out_valid (slot_valid[i]),
      .slot_out_pop   (slot_pop[i]),
      .slot_count     (slot_count[i]),
      .enq_err        (keeper_err[i])
    );
  end

endmodule

/* src/host_cmd_regs.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module host_cmd_regs (
  input  logic                                          clk,
  input  logic                                          rst_r,
  input  logic [31:0]                                   host_cmd,
  input  logic [31:0]                                   host_wr_data,
  input  logic                                          host_cmd_valid,
  output logic [31:0]                                   host_rd_data,
  input  sched_pkg::line_count_t [`SCHED_IF_COUNT-1:0]  line_count,
  input  sched_pkg::slot_t [`SCHED_CORE_COUNT-1:0]      slot_count,
  input  logic [`SCHED_IF_COUNT-1:0][31:0]              drop_count,
  output sched_pkg::core_mask_t                         income_cores,
  output sched_pkg::core_mask_t                         flush,
  output logic [`SCHED_IF_COUNT-1:0]                    almost_full
);

  import sched_pkg::*;

  localparam int CN = `SCHED_CORE_COUNT;

  // First stage holds the decoded command
  logic        wr_s1;
  logic [4:0]  reg_s1;
  core_id_t    core_idx_s1;
  if_id_t      if_idx_s1;
  logic [31:0] wr_data_s1;

  // Second stage holds write strobes and the readback value
  logic        wr_enable_s2;
  logic        wr_income_s2;
  logic        wr_flush_s2;
  logic        wr_limit_s2;
  logic [31:0] wr_data_s2;
  logic [31:0] rd_data_s2;

  core_mask_t  enabled_cores;
  line_count_t drop_limit;

  always_ff @(posedge clk) begin
    reg_s1      <= {host_cmd[30], host_cmd[3:0]};
    core_idx_s1 <= host_cmd[4 +: $bits(core_id_t)];
    if_idx_s1   <= host_cmd[4 +: $bits(if_id_t)];
    wr_data_s1  <= host_wr_data;
    wr_data_s2  <= wr_data_s1;
    host_rd_data <= rd_data_s2;
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wr_s1        <= 1'b0;
      wr_enable_s2 <= 1'b0;
      wr_income_s2 <= 1'b0;
      wr_flush_s2  <= 1'b0;
      wr_limit_s2  <= 1'b0;
    end else begin
      // Bit 31 marks a write, bit 29 addresses the scheduler
      wr_s1        <= host_cmd_valid && host_cmd[31] && host_cmd[29];
      wr_enable_s2 <= wr_s1 && (reg_s1 == CORE_ENABLE);
      wr_income_s2 <= wr_s1 && (reg_s1 == CORE_INCOME);
      wr_flush_s2  <= wr_s1 && (reg_s1 == CORE_FLUSH);
      wr_limit_s2  <= wr_s1 && (reg_s1 == IF_DROP_LIMIT);
    end
  end

  always_ff @(posedge clk) begin
    case (reg_s1)
      CORE_ENABLE:     rd_data_s2 <= 32'(enabled_cores);
      CORE_INCOME:     rd_data_s2 <= 32'(income_cores);
      CORE_SLOT_COUNT: rd_data_s2 <= 32'(slot_count[core_idx_s1]);
      IF_DROP_COUNT: begin
        if (int'(if_idx_s1) < `SCHED_IF_COUNT)
          rd_data_s2 <= drop_count[if_idx_s1];
        else
          rd_data_s2 <= `SCHED_RD_DEFAULT;
      end
      default:         rd_data_s2 <= `SCHED_RD_DEFAULT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      flush         <= '0;
      drop_limit    <= line_count_t'(`SCHED_DROP_LIMIT_RST);
      almost_full   <= '0;
    end else begin
      flush <= wr_flush_s2 ? wr_data_s2[CN-1:0] : '0;
      // A core leaving the enabled set stops taking traffic
      if (wr_enable_s2) begin
        enabled_cores <= wr_data_s2[CN-1:0];
        income_cores  <= income_cores & wr_data_s2[CN-1:0];
      end else if (wr_income_s2) begin
        income_cores  <= wr_data_s2[CN-1:0] & enabled_cores;
      end
      if (wr_limit_s2)
        drop_limit <= wr_data_s2[`SCHED_LINES_WIDTH-1:0];
      for (int i = 0; i < `SCHED_IF_COUNT; i++)
        almost_full[i] <= (line_count[i] >= drop_limit);
    end
  end

endmodule

/* src/desc_allocator.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module desc_allocator (
  input  logic                                     clk,
  input  logic                                     rst_r,
  input  logic [`SCHED_IF_COUNT-1:0]               hash_valid,
  input  sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]   hash_data,
  output logic [`SCHED_IF_COUNT-1:0]               hash_pop,
  output logic [`SCHED_IF_COUNT-1:0]               desc_push,
  output sched_pkg::alloc_desc_t                   desc_data,
  input  logic [`SCHED_IF_COUNT-1:0]               desc_fifo_ready,
  input  sched_pkg::core_mask_t                    income_cores,
  input  logic [`SCHED_IF_COUNT-1:0]               almost_full,
  input  sched_pkg::slot_t [`SCHED_CORE_COUNT-1:0] head_slot,
  input  sched_pkg::core_mask_t                    slot_valid,
  output sched_pkg::core_mask_t                    slot_pop,
  output logic [`SCHED_IF_COUNT-1:0][31:0]         drop_count
);

  import sched_pkg::*;

  localparam int IFN = `SCHED_IF_COUNT;

  logic [IFN-1:0] req;
  logic [IFN-1:0] grant;
  if_id_t         grant_if;
  logic           grant_v;
  if_id_t         last_if;
  if_id_t         cand;

  logic [IFN-1:0] grant_s1;
  if_id_t         grant_if_s1;
  logic           grant_v_s1;
  core_id_t       core_s1;
  logic           slot_ok;
  logic           take;
  logic           drop;

  // The interface granted last cycle is still waiting for its decision
  assign req = hash_valid & ~grant_s1 & desc_fifo_ready;

  // Round robin, starting after the last winner
  always_comb begin
    grant    = '0;
    grant_if = last_if;
    grant_v  = 1'b0;
    cand     = last_if;
    for (int k = 1; k <= IFN; k++) begin
      cand = if_id_t'((int'(last_if) + k) % IFN);
      if (!grant_v && req[cand]) begin
        grant[cand] = 1'b1;
        grant_if    = cand;
        grant_v     = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      last_if     <= if_id_t'(IFN - 1);
      grant_s1    <= '0;
      grant_v_s1  <= 1'b0;
      grant_if_s1 <= '0;
      core_s1     <= '0;
    end else begin
      if (grant_v)
        last_if <= grant_if;
      grant_s1    <= grant;
      grant_v_s1  <= grant_v;
      grant_if_s1 <= grant_if;
      core_s1     <= hash_data[grant_if][`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)];
    end
  end

  // Decision stage
  assign slot_ok   = slot_valid[core_s1] && income_cores[core_s1];
  assign take      = grant_v_s1 && slot_ok;
  assign drop      = grant_v_s1 && !slot_ok && almost_full[grant_if_s1];
  // Neither case leaves the hash at the FIFO head for a later retry
  assign hash_pop  = (take || drop) ? grant_s1 : '0;
  assign desc_push = hash_pop;
  assign slot_pop  = take ? (core_mask_t'(1) << core_s1) : '0;

  assign desc_data.drop = !slot_ok;
  assign desc_data.hash = hash_data[grant_if_s1];
  assign desc_data.core = core_s1;
  assign desc_data.slot = head_slot[core_s1];

  always_ff @(posedge clk) begin
    if (rst_r)
      drop_count <= '0;
    else if (drop)
      drop_count[grant_if_s1] <= drop_count[grant_if_s1] + 32'd1;
  end

endmodule

/* src/sched_top.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module sched_top (
  input  logic                                          clk,
  input  logic                                          rst_r,
  input  logic [`SCHED_IF_COUNT-1:0]                    hash_valid,
  input  sched_pkg::hash_t [`SCHED_IF_COUNT-1:0]        hash_data,
  output logic [`SCHED_IF_COUNT-1:0]                    hash_ready,
  output logic [`SCHED_IF_COUNT-1:0]                    desc_valid,
  output sched_pkg::alloc_desc_t [`SCHED_IF_COUNT-1:0]  desc_data,
  input  logic [`SCHED_IF_COUNT-1:0]                    desc_ready,
  input  logic                                          ctrl_valid,
  input  sched_pkg::ctrl_msg_t                          ctrl_data,
  input  sched_pkg::core_id_t                           ctrl_core,
  input  logic [31:0]                                   host_cmd,
  input  logic [31:0]                                   host_wr_data,
  input  logic                                          host_cmd_valid,
  output logic [31:0]                                   host_rd_data,
  input  sched_pkg::line_count_t [`SCHED_IF_COUNT-1:0]  line_count
);

  import sched_pkg::*;

  logic [`SCHED_IF_COUNT-1:0]        head_valid;
  hash_t [`SCHED_IF_COUNT-1:0]       head_hash;
  logic [`SCHED_IF_COUNT-1:0]        hash_pop;
  logic [`SCHED_IF_COUNT-1:0]        desc_push;
  alloc_desc_t                       alloc_desc;
  logic [`SCHED_IF_COUNT-1:0]        desc_fifo_ready;
  slot_t [`SCHED_CORE_COUNT-1:0]     head_slot;
  slot_t [`SCHED_CORE_COUNT-1:0]     slot_count;
  core_mask_t                        slot_valid;
  core_mask_t                        slot_pop;
  core_mask_t                        flush;
  core_mask_t                        income_cores;
  logic [`SCHED_IF_COUNT-1:0]        almost_full;
  logic [`SCHED_IF_COUNT-1:0][31:0]  drop_count;

  for (genvar i = 0; i < `SCHED_IF_COUNT; i++) begin : g_if
    // Hashes wait here for a grant
    sched_fifo #(
      .payload_t (hash_t),
      .DEPTH     (`SCHED_HASH_FIFO_DEPTH)
    ) u_hash_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_valid  (hash_valid[i]),
      .in_data   (hash_data[i]),
      .in_ready  (hash_ready[i]),
      .out_valid (head_valid[i]),
      .out_data  (head_hash[i]),
      .out_ready (hash_pop[i])
    );

    // Finished descriptors, in arrival order per interface
    sched_fifo #(
      .payload_t (alloc_desc_t),
      .DEPTH     (`SCHED_DESC_FIFO_DEPTH)
    ) u_desc_fifo (
      .clk       (clk),
      .rst_r     (rst_r),
      .in_valid  (desc_push[i]),
      .in_data   (alloc_desc),
      .in_ready  (desc_fifo_ready[i]),
      .out_valid (desc_valid[i]),
      .out_data  (desc_data[i]),
      .out_ready (desc_ready[i])
    );
  end

  // Core messages are taken every valid cycle
  core_slot_pool u_pool (
    .clk        (clk),
    .rst_r      (rst_r),
    .ctrl_valid (ctrl_valid),
    .ctrl_data  (ctrl_data),
    .ctrl_core  (ctrl_core),
    .flush      (flush),
    .slot_pop   (slot_pop),
    .head_slot  (head_slot),
    .slot_valid (slot_valid),
    .slot_count (slot_count),
    .slot_err   ()
  );

  host_cmd_regs u_host (
    .clk            (clk),
    .rst_r          (rst_r),
    .host_cmd       (host_cmd),
    .host_wr_data   (host_wr_data),
    .host_cmd_valid (host_cmd_valid),
    .host_rd_data   (host_rd_data),
    .line_count     (line_count),
    .slot_count     (slot_count),
    .drop_count     (drop_count),
    .income_cores   (income_cores),
    .flush          (flush),
    .almost_full    (almost_full)
  );

  desc_allocator u_alloc (
    .clk             (clk),
    .rst_r           (rst_r),
    .hash_valid      (head_valid),
    .hash_data       (head_hash),
    .hash_pop        (hash_pop),
    .desc_push       (desc_push),
    .desc_data       (alloc_desc),
    .desc_fifo_ready (desc_fifo_ready),
    .income_cores    (income_cores),
    .almost_full     (almost_full),
    .head_slot       (head_slot),
    .slot_valid      (slot_valid),
    .slot_pop        (slot_pop),
    .drop_count      (drop_count)
  );

endmodule

/* test/sched_properties.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module sched_properties (
  input  logic                                          clk,
  input  logic                                          rst_r,
  input  logic [`SCHED_IF_COUNT-1:0]                    hash_valid,
  input  logic [`SCHED_IF_COUNT-1:0]                    hash_ready,
  input  logic [`SCHED_IF_COUNT-1:0]                    head_valid,
  input  logic [`SCHED_IF_COUNT-1:0]                    hash_pop,
  input  logic [`SCHED_IF_COUNT-1:0]                    desc_valid,
  input  logic [`SCHED_IF_COUNT-1:0]                    desc_ready,
  input  sched_pkg::alloc_desc_t [`SCHED_IF_COUNT-1:0]  desc_data
);

  import sched_pkg::*;

  // Hashes taken by the handshake minus hashes popped by the allocator
  logic [4:0] occ [`SCHED_IF_COUNT];

  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int i = 0; i < `SCHED_IF_COUNT; i++)
        occ[i] <= '0;
    end else begin
      for (int i = 0; i < `SCHED_IF_COUNT; i++)
        occ[i] <= occ[i] + 5'(hash_valid[i] && hash_ready[i]) - 5'(hash_pop[i]);
    end
  end

  for (genvar i = 0; i < `SCHED_IF_COUNT; i++) begin : g_if
    a_desc_hold: assert property (@(posedge clk) disable iff (rst_r)
      desc_valid[i] && !desc_ready[i] |=> desc_valid[i] && $stable(desc_data[i]))
      else $error("descriptor changed or vanished while stalled");

    // A hash that slipped in with ready low would show up at the head
    a_hash_accept: assert property (@(posedge clk) disable iff (rst_r)
      head_valid[i] == (occ[i] != 5'd0))
      else $error("hash FIFO holds a hash that was not accepted");
  end

  a_reset_quiet: assert property (@(posedge clk)
    rst_r |=> (desc_valid == '0) && (hash_ready == '0))
    else $error("outputs active during reset");

endmodule

bind sched_top sched_properties u_props (
  .clk        (clk),
  .rst_r      (rst_r),
  .hash_valid (hash_valid),
  .hash_ready (hash_ready),
  .head_valid (head_valid),
  .hash_pop   (hash_pop),
  .desc_valid (desc_valid),
  .desc_ready (desc_ready),
  .desc_data  (desc_data)
);

/* test/sched_tb.sv */
`timescale 1ns/1ps
`include "sched_settings.svh"

module sched_tb;

  import sched_pkg::*;

  localparam int IFN = `SCHED_IF_COUNT;
  localparam int K_WR    = 0;
  localparam int K_RD    = 1;
  localparam int K_CTRL  = 2;
  localparam int K_LINES = 3;
  localparam int K_HASH  = 4;
  localparam int K_HOLD  = 5;
  localparam int K_PEND  = 6;
  localparam int K_BURST = 7;

  // arg is the register, message type or line count; val the write data,
  // returned slot or expected drop; exp the readback or first slot
  typedef struct {
    int          kind;
    string       name;
    int          ifx;
    int          core;
    logic [31:0] arg;
    logic [31:0] val;
    logic [31:0] exp;
  } step_t;

  logic                    clk;
  logic                    rst_r;
  logic [IFN-1:0]          hash_valid;
  hash_t [IFN-1:0]         hash_data;
  logic [IFN-1:0]          hash_ready;
  logic [IFN-1:0]          desc_valid;
  alloc_desc_t [IFN-1:0]   desc_data;
  logic [IFN-1:0]          desc_ready;
  logic                    ctrl_valid;
  ctrl_msg_t               ctrl_data;
  core_id_t                ctrl_core;
  logic [31:0]             host_cmd;
  logic [31:0]             host_wr_data;
  logic                    host_cmd_valid;
  logic [31:0]             host_rd_data;
  line_count_t [IFN-1:0]   line_count;

  step_t       steps [$];
  logic [31:0] rng;
  logic [31:0] pend_hash [IFN];
  int          errors;

  sched_top u_dut (
    .clk            (clk),
    .rst_r          (rst_r),
    .hash_valid     (hash_valid),
    .hash_data      (hash_data),
    .hash_ready     (hash_ready),
    .desc_valid     (desc_valid),
    .desc_data      (desc_data),
    .desc_ready     (desc_ready),
    .ctrl_valid     (ctrl_valid),
    .ctrl_data      (ctrl_data),
    .ctrl_core      (ctrl_core),
    .host_cmd       (host_cmd),
    .host_wr_data   (host_wr_data),
    .host_cmd_valid (host_cmd_valid),
    .host_rd_data   (host_rd_data),
    .line_count     (line_count)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Random hash steered to one core by the select bits
  function automatic logic [31:0] make_hash(input logic [31:0] r, input int core);
    logic [31:0] h;
    h = r;
    h[`SCHED_HASH_SEL_OFFSET +: 3] = 3'(core);
    return h;
  endfunction

  function automatic logic [31:0] cmd_word(input logic wr, input logic [31:0] r, input int idx);
    logic [31:0] c;
    c = '0;
    c[31] = wr;
    c[30] = r[4];
    c[29] = wr;
    c[11:4] = 8'(idx);
    c[3:0] = r[3:0];
    return c;
  endfunction

  task automatic add(input int kind, input string name, input int ifx, input int core,
                     input logic [31:0] arg, input logic [31:0] val, input logic [31:0] exp);
    step_t s;
    s.kind = kind;
    s.name = name;
    s.ifx  = ifx;
    s.core = core;
    s.arg  = arg;
    s.val  = val;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  task automatic fail_run(input string msg);
    errors++;
    $display("[ERROR] %s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic host_write(input logic [31:0] cmd, input logic [31:0] data);
    @(negedge clk);
    host_cmd       = cmd;
    host_wr_data   = data;
    host_cmd_valid = 1'b1;
    @(negedge clk);
    host_cmd_valid = 1'b0;
    repeat (5) @(negedge clk);
  endtask

  task automatic host_read(input logic [31:0] cmd, output logic [31:0] rd);
    @(negedge clk);
    host_cmd = cmd;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rd = host_rd_data;
  endtask

  task automatic send_ctrl(input logic [3:0] kind, input int core, input logic [5:0] slot);
    @(negedge clk);
    ctrl_valid         = 1'b1;
    ctrl_data          = '0;
    ctrl_data.msg_type = kind;
    ctrl_data.slot     = slot;
    ctrl_core          = 3'(core);
    @(negedge clk);
    ctrl_valid = 1'b0;
    repeat (4) @(negedge clk);
  endtask

  task automatic push_hash(input int ifx, input logic [31:0] h);
    int n;
    n = 0;
    @(negedge clk);
    while (!hash_ready[ifx]) begin
      n++;
      if (n > 50)
        fail_run("hash_ready stayed low while pushing a hash");
      @(negedge clk);
    end
    hash_valid[ifx] = 1'b1;
    hash_data[ifx]  = h;
    @(negedge clk);
    hash_valid[ifx] = 1'b0;
  endtask

  // Samples the head descriptor from the current falling edge on
  task automatic wait_desc(input int ifx, output alloc_desc_t d);
    int n;
    n = 0;
    while (!desc_valid[ifx]) begin
      n++;
      if (n > 50)
        fail_run("no descriptor arrived in time");
      @(negedge clk);
    end
    d = desc_data[ifx];
  endtask

  task automatic burst(input step_t st);
    logic [31:0] q [$];
    logic [31:0] h;
    alloc_desc_t d;
    bit          fell;
    fell = 0;
    @(negedge clk);
    desc_ready[st.ifx] = 1'b0;
    for (int k = 0; k < 40 && !fell; k++) begin
      @(negedge clk);
      if (hash_ready[st.ifx]) begin
        rng = xorshift(rng);
        h = make_hash(rng, st.core);
        q.push_back(h);
        hash_valid[st.ifx] = 1'b1;
        hash_data[st.ifx]  = h;
      end else begin
        hash_valid[st.ifx] = 1'b0;
        fell = 1;
      end
    end
    hash_valid[st.ifx] = 1'b0;
    if (!fell)
      fail_run("hash_ready did not fall under descriptor back-pressure");
    repeat (5) @(negedge clk);
    desc_ready[st.ifx] = 1'b1;
    foreach (q[k]) begin
      wait_desc(st.ifx, d);
      check({st.name, " hash"}, 64'(q[k]), 64'(d.hash));
      check({st.name, " drop"}, 64'(0), 64'(d.drop));
      check({st.name, " slot"}, 64'(st.exp + 32'(k)), 64'(d.slot));
      // Each descriptor leaves the FIFO at the next rising edge
      @(negedge clk);
    end
  endtask

  task automatic build_table();
    add(K_WR, "enable all", 0, 0, 32'(CORE_ENABLE), 32'hFF, 0);
    add(K_WR, "income low", 0, 0, 32'(CORE_INCOME), 32'h0F, 0);
    add(K_RD, "read enable", 0, 0, 32'(CORE_ENABLE), 0, 32'hFF);
    add(K_RD, "read income", 0, 0, 32'(CORE_INCOME), 0, 32'h0F);
    add(K_WR, "shrink enable", 0, 0, 32'(CORE_ENABLE), 32'h0B, 0);
    add(K_RD, "income masked", 0, 0, 32'(CORE_INCOME), 0, 32'h0B);
    add(K_WR, "income all", 0, 0, 32'(CORE_INCOME), 32'hFF, 0);
    add(K_RD, "income limited", 0, 0, 32'(CORE_INCOME), 0, 32'h0B);
    add(K_RD, "unknown reg", 0, 0, 32'h07, 0, `SCHED_RD_DEFAULT);
    add(K_WR, "enable again", 0, 0, 32'(CORE_ENABLE), 32'hFF, 0);
    add(K_WR, "income 0-5", 0, 0, 32'(CORE_INCOME), 32'h3F, 0);
    // Core 1 with four slots
    add(K_CTRL, "init core1", 0, 1, 32'd3, 32'd4, 0);
    add(K_RD, "count core1 init", 0, 1, 32'(CORE_SLOT_COUNT), 0, 32'd4);
    add(K_HASH, "if0 core1 a", 0, 1, 0, 32'd0, 32'd1);
    add(K_HASH, "if1 core1 b", 1, 1, 0, 32'd0, 32'd2);
    add(K_HASH, "if2 core1 c", 2, 1, 0, 32'd0, 32'd3);
    add(K_RD, "count core1 left", 0, 1, 32'(CORE_SLOT_COUNT), 0, 32'd1);
    add(K_CTRL, "return 9", 0, 1, 32'd0, 32'd9, 0);
    add(K_RD, "count after return", 0, 1, 32'(CORE_SLOT_COUNT), 0, 32'd2);
    add(K_HASH, "if0 core1 d", 0, 1, 0, 32'd0, 32'd4);
    add(K_HASH, "if1 returned", 1, 1, 0, 32'd0, 32'd9);
    add(K_RD, "count core1 empty", 0, 1, 32'(CORE_SLOT_COUNT), 0, 32'd0);
    // Drop path on interface 1
    add(K_WR, "drop limit", 0, 0, 32'(IF_DROP_LIMIT), 32'd100, 0);
    add(K_LINES, "if1 full", 1, 0, 32'd200, 0, 0);
    add(K_HASH, "if1 drop", 1, 1, 0, 32'd1, 0);
    add(K_RD, "drop count if1", 1, 0, 32'(IF_DROP_COUNT), 0, 32'd1);
    add(K_RD, "drop count if0", 0, 0, 32'(IF_DROP_COUNT), 0, 32'd0);
    add(K_HOLD, "if0 waits", 0, 1, 0, 0, 0);
    add(K_CTRL, "return 5", 0, 1, 32'd0, 32'd5, 0);
    add(K_PEND, "if0 released", 0, 1, 0, 0, 32'd5);
    // Flush and income mask
    add(K_CTRL, "init core2", 0, 2, 32'd3, 32'd10, 0);
    add(K_RD, "count core2", 0, 2, 32'(CORE_SLOT_COUNT), 0, 32'd10);
    add(K_WR, "flush core2", 0, 0, 32'(CORE_FLUSH), 32'h04, 0);
    add(K_RD, "count core2 flushed", 0, 2, 32'(CORE_SLOT_COUNT), 0, 32'd0);
    add(K_CTRL, "init core6", 0, 6, 32'd3, 32'd3, 0);
    add(K_HASH, "if1 not income", 1, 6, 0, 32'd1, 0);
    add(K_RD, "drop count if1 again", 1, 0, 32'(IF_DROP_COUNT), 0, 32'd2);
    add(K_RD, "count core6 kept", 0, 6, 32'(CORE_SLOT_COUNT), 0, 32'd3);
    // Back-pressure burst
    add(K_LINES, "if1 drained", 1, 0, 32'd0, 0, 0);
    add(K_CTRL, "init core3", 0, 3, 32'd3, 32'd32, 0);
    add(K_BURST, "burst if2", 2, 3, 0, 0, 32'd1);
  endtask

  task automatic run_step(input step_t st);
    logic [31:0] rd;
    logic [31:0] h;
    alloc_desc_t d;
    case (st.kind)
      K_WR: host_write(cmd_word(1'b1, st.arg, st.core), st.val);
      K_RD: begin
        host_read(cmd_word(1'b0, st.arg, (st.arg[4] ? st.ifx : st.core)), rd);
        check(st.name, 64'(st.exp), 64'(rd));
      end
      K_CTRL: send_ctrl(st.arg[3:0], st.core, st.val[5:0]);
      K_LINES: begin
        @(negedge clk);
        line_count[st.ifx] = st.arg[`SCHED_LINES_WIDTH-1:0];
        repeat (4) @(negedge clk);
      end
      K_HASH: begin
        rng = xorshift(rng);
        h = make_hash(rng, st.core);
        push_hash(st.ifx, h);
        wait_desc(st.ifx, d);
        check({st.name, " hash"}, 64'(h), 64'(d.hash));
        check({st.name, " drop"}, 64'(st.val[0]), 64'(d.drop));
        check({st.name, " core"}, 64'(st.core), 64'(d.core));
        if (!st.val[0])
          check({st.name, " slot"}, 64'(st.exp), 64'(d.slot));
      end
      K_HOLD: begin
        rng = xorshift(rng);
        h = make_hash(rng, st.core);
        pend_hash[st.ifx] = h;
        // The late descriptor stays in its FIFO until it is read
        desc_ready[st.ifx] = 1'b0;
        push_hash(st.ifx, h);
        repeat (20) begin
          @(negedge clk);
          check({st.name, " no descriptor"}, 64'(0), 64'(desc_valid[st.ifx]));
        end
      end
      K_PEND: begin
        wait_desc(st.ifx, d);
        check({st.name, " hash"}, 64'(pend_hash[st.ifx]), 64'(d.hash));
        check({st.name, " drop"}, 64'(0), 64'(d.drop));
        check({st.name, " slot"}, 64'(st.exp), 64'(d.slot));
        desc_ready[st.ifx] = 1'b1;
        @(negedge clk);
      end
      default: burst(st);
    endcase
  endtask

  initial begin
    clk            = 1'b0;
    rst_r          = 1'b1;
    hash_valid     = '0;
    hash_data      = '0;
    desc_ready     = '1;
    ctrl_valid     = 1'b0;
    ctrl_data      = '0;
    ctrl_core      = '0;
    host_cmd       = '0;
    host_wr_data   = '0;
    host_cmd_valid = 1'b0;
    line_count     = '0;
    rng            = 32'hcc1b7863;
    errors         = 0;
    build_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_r = 1'b0;
    repeat (3) @(negedge clk);
    foreach (steps[i])
      run_step(steps[i]);
    repeat (5) @(negedge clk);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "checks failed");
    end
  end

  // Budget grows with the length of the step table
  initial begin
    @(negedge rst_r);
    repeat ((steps.size() + 10) * 50) @(posedge clk);
    $display("[ERROR] watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

endmodule

/* sim.f */
+incdir+src
src/sched_pkg.sv
src/sched_fifo.sv
src/slot_keeper.sv
src/core_slot_pool.sv
src/host_cmd_regs.sv
src/desc_allocator.sv
src/sched_top.sv
test/sched_properties.sv
test/sched_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module sched_tb -f sim.f
	out=$$(./obj_dir/Vsched_tb); status=$$?; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED" && [ $$status -eq 0 ]

clean:
	rm -rf obj_dir
